// ==== compile.f ====
+incdir+common
common/cpu_pkg.sv
hdl/regfile.sv
hdl/decoder.sv
hdl/ex_alu.sv
hdl/cpu_core.sv
verification/cpu_core_props.sv
verification/tb_cpu_core.sv

// ==== verification/tb_cpu_core.sv ====
/* testbench for cpu_core with an instruction table, a shadow register model,
   random commit back-pressure and a watchdog */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu_core import cpu_pkg::*;;

    localparam int NUM_ROWS   = 21;
    localparam int NUM_PASSES = 2; // full rate first and then random out_ready
    localparam int CLK_PERIOD = 100;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * NUM_PASSES * 40 + 4;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    in_valid;
    inst_t   in_inst;
    logic    in_ready;
    logic    out_valid;
    commit_t out_commit;
    logic    out_ready;

    inst_t   row_inst [NUM_ROWS];
    word_t   row_exp [NUM_ROWS];
    int      n_rows = 0;
    word_t   shadow [`REG_COUNT];
    commit_t exp_q [$];
    commit_t expected;
    int      errors = 0;
    int      checks = 0;
    logic    bp_phase = 1'b0;
    integer  seed = 32'h1bb5_1b4c;
    integer  rnd;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_core dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_commit (out_commit),
        .out_ready  (out_ready)
    );

    function automatic inst_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic inst_t u_type(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, `OPC_LUI};
    endfunction

    task automatic add_row(input inst_t inst, input word_t exp_result);
        row_inst[n_rows] = inst;
        row_exp[n_rows]  = exp_result;
        n_rows++;
    endtask

    // reference ALU from the RV32I rules
    function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                         input word_t a, input word_t b);
        int sh;
        sh = b[4:0];
        case (f3)
            `F3_ADD:  return alt ? a + ~b + 1 : a + b;
            `F3_SLL:  return a << sh;
            `F3_SLT:  return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            `F3_SLTU: return word_t'(a < b);
            `F3_XOR:  return a ^ b;
            `F3_SR:   return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            `F3_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    // expected record in program order and the matching shadow register update
    function automatic commit_t predict_commit(input inst_t inst);
        commit_t    c;
        word_t      a;
        word_t      b;
        logic [2:0] f3;
        f3        = inst[14:12];
        a         = shadow[inst[19:15]];
        b         = shadow[inst[24:20]];
        c.rd      = inst[11:7];
        c.result  = '0;
        c.wr_en   = (inst[11:7] != 5'd0);
        c.illegal = 1'b0;
        case (inst[6:0])
            `OPC_OP:     c.result = alu_result(f3, inst[30], a, b);
            `OPC_OP_IMM: c.result = alu_result(f3, inst[30] && (f3 == `F3_SR), a,
                                               {{20{inst[31]}}, inst[31:20]});
            `OPC_LUI:    c.result = {inst[31:12], 12'h000};
            default: begin
                c.illegal = 1'b1;
                c.wr_en   = 1'b0;
            end
        endcase
        if (c.wr_en)
            shadow[c.rd] = c.result;
        return c;
    endfunction

    // illegal records carry no defined rd or result
    function automatic logic records_match(input commit_t got, input commit_t exp);
        if (got.illegal != exp.illegal || got.wr_en != exp.wr_en)
            return 1'b0;
        return exp.illegal || (got.rd == exp.rd && got.result == exp.result);
    endfunction

    task automatic load_table();
        add_row(i_type(12'hffb, 5'd0, `F3_ADD, 5'd1), 32'hffff_fffb);  // addi x1, x0, -5
        add_row(i_type(12'hffd, 5'd1, `F3_ADD, 5'd2), 32'hffff_fff8);  // dependent at distance 1
        add_row(i_type(12'hffc, 5'd1, `F3_SLT, 5'd3), 32'h0000_0001);
        add_row(i_type(12'hfff, 5'd2, `F3_SLTU, 5'd4), 32'h0000_0001); // distance 2 on x2
        add_row(i_type(12'h0f0, 5'd1, `F3_XOR, 5'd5), 32'hffff_ff0b);
        add_row(i_type(12'h0ff, 5'd5, `F3_AND, 5'd6), 32'h0000_000b);
        add_row(i_type(12'h700, 5'd6, `F3_OR, 5'd7), 32'h0000_070b);
        add_row(i_type(12'h014, 5'd7, `F3_SLL, 5'd8), 32'h70b0_0000);
        add_row(i_type(12'h402, 5'd2, `F3_SR, 5'd9), 32'hffff_fffe);   // srai
        add_row(i_type(12'h01c, 5'd1, `F3_SR, 5'd10), 32'h0000_000f);  // srli
        add_row(r_type(7'h20, 5'd1, 5'd7, `F3_ADD, 5'd11), 32'h0000_0710);
        add_row(r_type(7'h00, 5'd11, 5'd3, `F3_SLL, 5'd12), 32'h0001_0000); // x11 at distance 1
        add_row(r_type(7'h20, 5'd11, 5'd5, `F3_SR, 5'd13), 32'hffff_ffff);  // x11 at distance 2
        add_row(r_type(7'h00, 5'd3, 5'd1, `F3_SLT, 5'd14), 32'h0000_0001);
        add_row(r_type(7'h00, 5'd3, 5'd1, `F3_SLTU, 5'd15), 32'h0000_0000);
        add_row(u_type(20'h12345, 5'd0), 32'h1234_5000);               // lui to x0
        add_row(u_type(20'habcde, 5'd16), 32'habcd_e000);
        add_row({7'h00, 5'd1, 5'd2, 3'b010, 5'd12, 7'b0100011}, 32'h0); // sw x1, 12(x2)
        add_row({7'h00, 5'd4, 5'd3, 3'b000, 5'd8, 7'b1100011}, 32'h0);  // beq x3, x4, +8
        add_row(r_type(7'h00, 5'd1, 5'd0, `F3_OR, 5'd17), 32'hffff_fffb);
        add_row(r_type(7'h00, 5'd8, 5'd12, `F3_ADD, 5'd18), 32'h70b1_0000);
        for (int r = 0; r < `REG_COUNT; r++)
            shadow[r] = '0;
    endtask

    always @(posedge clk) begin
        rnd = $random(seed);
        if (bp_phase)
            out_ready <= rnd[0];
        else
            out_ready <= 1'b1;
    end

    // a record seen here with out_ready high is taken on the next rising edge
    always @(negedge clk) begin
        if (rst_n === 1'b1 && out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("record delivered at %0t with no instruction outstanding", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                checks++;
                assert (records_match(out_commit, expected)) else begin
                    $display("ERROR %0t: got x%0d=%h we=%b ill=%b, expected x%0d=%h we=%b ill=%b",
                             $time, out_commit.rd, out_commit.result, out_commit.wr_en,
                             out_commit.illegal, expected.rd, expected.result,
                             expected.wr_en, expected.illegal);
                    errors++;
                end
            end
        end
    end

    initial begin
        int      errs_at_start;
        commit_t rec;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_inst   = '0;
        out_ready = 1'b1;
        load_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            errs_at_start = errors;
            for (int i = 0; i < NUM_ROWS; i++) begin
                rec = predict_commit(row_inst[i]);
                assert (rec.illegal || rec.result == row_exp[i]) else begin
                    $display("ERROR %0t: table row %0d expects %h, reference model gives %h",
                             $time, i, row_exp[i], rec.result);
                    errors++;
                end
                exp_q.push_back(rec);
                in_valid <= 1'b1;
                in_inst  <= row_inst[i];
                do
                    @(negedge clk);
                while (!in_ready);
                @(posedge clk);
            end
            in_valid <= 1'b0;
            while (exp_q.size() != 0)
                @(negedge clk);
            $display("test %0d (%s): %0d records, %0d errors", pass + 1,
                     (pass == 0) ? "full rate" : "random out_ready", NUM_ROWS,
                     errors - errs_at_start);
            bp_phase = 1'b1;
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (dut_i.props_i.failures != 0) begin
            $display("bound property checks failed %0d times", dut_i.props_i.failures);
            errors += dut_i.props_i.failures;
        end
        assert (checks == NUM_ROWS * NUM_PASSES) else begin
            $display("only %0d of %0d records were delivered", checks, NUM_ROWS * NUM_PASSES);
            errors++;
        end
        $display("%0d records checked, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the pipeline stopped delivering commit records");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/cpu_core_props.sv ====
/* bound checks on the reset state and the commit handshake of cpu_core */
`timescale 1ns/100ps
`default_nettype none

module cpu_core_props import cpu_pkg::*; (
    input wire logic    clk,
    input wire logic    rst_n,
    input wire logic    out_valid,
    input wire logic    out_ready,
    input wire commit_t out_commit
);

    int failures = 0;

    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid is high in the cycle after reset");
            failures++;
        end

    // a stalled record may not change until it is taken
    stalled_record_holds: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_commit))
        else begin
            $error("commit record changed or vanished while out_ready was low");
            failures++;
        end

    illegal_never_writes: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !(out_commit.illegal && out_commit.wr_en))
        else begin
            $error("illegal instruction retired with wr_en set");
            failures++;
        end

endmodule

bind cpu_core cpu_core_props props_i (.*);

`default_nettype wire

// ==== hdl/cpu_core.sv ====
/* single-issue RV32I integer core: stream ports, advance control
   and the decode-time bypass around the register file */
`timescale 1ns/100ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  in_valid,
    input  wire inst_t in_inst,
    output logic       in_ready,
    output logic       out_valid,
    output commit_t    out_commit,
    input  wire logic  out_ready
);

    logic     advance;
    logic     in_fire;
    logic     wr_fire;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rf_a;
    word_t    rf_b;
    word_t    rs1_val;
    word_t    rs2_val;
    logic     dec_valid;
    decoded_t dec;

    // returns the pending commit result when it targets idx
    function automatic word_t bypass(
        input reg_idx_t idx,
        input word_t    rf_val,
        input logic     rec_valid,
        input commit_t  rec
    );
        if (rec_valid && rec.wr_en && (rec.rd != '0) && (rec.rd == idx))
            return rec.result;
        return rf_val;
    endfunction

    // whole pipeline moves together, stalled only by a full output register
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;
    assign in_fire  = in_valid && advance;
    assign wr_fire  = out_valid && out_ready; // write back on delivery

    assign rs1_val = bypass(rs1, rf_a, out_valid, out_commit);
    assign rs2_val = bypass(rs2, rf_b, out_valid, out_commit);

    decoder decoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .in_fire   (in_fire),
        .inst      (in_inst),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .rs1       (rs1),
        .rs2       (rs2),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_idx_a (rs1),
        .rd_idx_b (rs2),
        .rd_val_a (rf_a),
        .rd_val_b (rf_b),
        .wr_fire  (wr_fire),
        .wr       (out_commit)
    );

    ex_alu ex_alu_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .out_valid  (out_valid),
        .out_commit (out_commit)
    );

endmodule

`default_nettype wire

// ==== hdl/ex_alu.sv ====
/* execute stage: late operand bypass, ALU and the commit output register */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module ex_alu import cpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     advance,
    input  wire logic     dec_valid,
    input  wire decoded_t dec,
    output logic          out_valid,
    output commit_t       out_commit
);

    logic       fwd_a;
    logic       fwd_b;
    word_t      src_a;
    word_t      src_b;
    logic [4:0] shamt;
    word_t      result;

    // producer still sits in the commit register, not yet in the regfile
    assign fwd_a = out_valid && out_commit.wr_en && (out_commit.rd != '0)
                   && (out_commit.rd == dec.rs1);
    assign fwd_b = out_valid && out_commit.wr_en && (out_commit.rd != '0)
                   && dec.use_rs2 && (out_commit.rd == dec.rs2);

    assign src_a = fwd_a ? out_commit.result : dec.op_a;
    assign src_b = fwd_b ? out_commit.result : dec.op_b;
    assign shamt = src_b[4:0];

    always_comb begin
        case (dec.alu_op[2:0])
            `F3_ADD:  result = dec.alu_op[3] ? src_a - src_b : src_a + src_b;
            `F3_SLL:  result = src_a << shamt;
            `F3_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            `F3_SLTU: result = {{(`XLEN-1){1'b0}}, src_a < src_b};
            `F3_XOR:  result = src_a ^ src_b;
            `F3_SR: begin
                if (dec.alu_op[3])
                    result = word_t'($signed(src_a) >>> shamt); // sra
                else
                    result = src_a >> shamt;
            end
            `F3_OR:   result = src_a | src_b;
            `F3_AND:  result = src_a & src_b;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (advance)
            out_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_commit.rd      <= dec.rd;
            out_commit.result  <= result;
            out_commit.wr_en   <= dec.wr_en;
            out_commit.illegal <= dec.illegal;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
/* decode stage: field extraction, immediate build and the decode register */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module decoder import cpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     advance,
    input  wire logic     in_fire,
    input  wire inst_t    inst,
    input  wire word_t    rs1_val,
    input  wire word_t    rs2_val,
    output reg_idx_t      rs1,
    output reg_idx_t      rs2,
    output logic          dec_valid,
    output decoded_t      dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    alu_op_t    alu_op;
    reg_idx_t   rd;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    logic       use_rs2;
    word_t      imm;
    logic       wr_en;
    logic       illegal;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];

    always_comb begin
        alu_op  = {1'b0, `F3_ADD};
        rs1_idx = '0;
        rs2_idx = '0;
        use_rs2 = 1'b0;
        imm     = {{(`XLEN-12){inst[31]}}, inst[31:20]}; // I-type
        wr_en   = 1'b0;
        illegal = 1'b0;
        case (opcode)
            `OPC_OP: begin
                alu_op  = {inst[30], funct3};
                rs1_idx = inst[19:15];
                rs2_idx = inst[24:20];
                use_rs2 = 1'b1;
                wr_en   = 1'b1;
            end
            `OPC_OP_IMM: begin
                // bit 30 is part of the immediate except for srai
                alu_op  = {(funct3 == `F3_SR) & inst[30], funct3};
                rs1_idx = inst[19:15];
                wr_en   = 1'b1;
            end
            `OPC_LUI: begin
                imm   = {inst[31:12], 12'b0};
                wr_en = 1'b1; // x0 + imm
            end
            default: illegal = 1'b1;
        endcase
        if (rd == '0)
            wr_en = 1'b0;
    end

    // register indices go out to the register file read ports
    assign rs1 = rs1_idx;
    assign rs2 = rs2_idx;

    always_ff @(posedge clk) begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else if (advance)
            dec_valid <= in_fire;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            dec.alu_op  <= alu_op;
            dec.rd      <= rd;
            dec.rs1     <= rs1_idx;
            dec.rs2     <= rs2_idx;
            dec.use_rs2 <= use_rs2;
            dec.op_a    <= rs1_val; // reads zero for lui and illegal forms
            dec.op_b    <= use_rs2 ? rs2_val : imm;
            dec.wr_en   <= wr_en;
            dec.illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
/* architectural register file, two async read ports and one write port */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module regfile import cpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire reg_idx_t rd_idx_a,
    input  wire reg_idx_t rd_idx_b,
    output word_t         rd_val_a,
    output word_t         rd_val_b,
    input  wire logic     wr_fire,
    input  wire commit_t  wr
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_fire && wr.wr_en) begin
            regs[wr.rd] <= wr.result;
        end
    end

    // x0 is hardwired
    assign rd_val_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
    assign rd_val_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== common/cpu_pkg.sv ====
/* vector types and the decode and commit records of the core */
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`XLEN-1:0]      inst_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // bit 3 is the alternate bit (sub, sra), bits 2:0 are funct3
    typedef logic [3:0] alu_op_t;

    // contents of the decode register
    typedef struct packed {
        alu_op_t  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_rs2;  // clear for immediate forms
        word_t    op_a;
        word_t    op_b;     // holds the immediate when use_rs2 is clear
        logic     wr_en;
        logic     illegal;
    } decoded_t;

    // retired instruction, also the register file write source
    typedef struct packed {
        reg_idx_t rd;
        word_t    result;
        logic     wr_en;
        logic     illegal;
    } commit_t;

endpackage

`default_nettype wire

// ==== common/cpu_settings.svh ====
/* widths, register count, major opcodes and funct3 codes of the integer core */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define XLEN      32
`define REG_COUNT 32
`define REG_IDX_W 5

// major opcodes the decoder executes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111

`define F3_ADD  3'b000 // add, sub
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101 // srl, sra
`define F3_OR   3'b110
`define F3_AND  3'b111

`endif
